// File: common/lcst_defines.svh
// Lifecycle translator widths and constants
// Shared by the top level and the capture stage

`ifndef LCST_DEFINES_SVH
`define LCST_DEFINES_SVH

// --------------------
// Bus widths
// --------------------

// Unlock level and the three SoC masks
`define LCST_MASK_W 64

// Compact lifecycle state code
`define LCST_CODE_W 5

// Debug-enable token from the lifecycle controller
`define LCST_TOKEN_W 4

// --------------------
// Token encoding
// --------------------

// Only this exact pattern counts as enabled
`define LCST_TOKEN_ON 4'b0101

`endif

// File: common/lcst_pkg.sv
// Lifecycle translator types
// Lifecycle code, translator state and core security state

`default_nettype none

`include "lcst_defines.svh"

package lcst_pkg;

  // --------------------
  // Lifecycle code
  // --------------------

  // Codes 21 to 31 are invalid
  typedef enum logic [`LCST_CODE_W-1:0] {
    LC_RAW             = 5'd0,
    LC_TEST_UNLOCKED0  = 5'd1,
    LC_TEST_UNLOCKED1  = 5'd2,
    LC_TEST_UNLOCKED2  = 5'd3,
    LC_TEST_UNLOCKED3  = 5'd4,
    LC_TEST_UNLOCKED4  = 5'd5,
    LC_TEST_UNLOCKED5  = 5'd6,
    LC_TEST_UNLOCKED6  = 5'd7,
    LC_TEST_UNLOCKED7  = 5'd8,
    LC_TEST_LOCKED0    = 5'd9,
    LC_TEST_LOCKED1    = 5'd10,
    LC_TEST_LOCKED2    = 5'd11,
    LC_TEST_LOCKED3    = 5'd12,
    LC_TEST_LOCKED4    = 5'd13,
    LC_TEST_LOCKED5    = 5'd14,
    LC_TEST_LOCKED6    = 5'd15,
    LC_DEV             = 5'd16,
    LC_PROD            = 5'd17,
    LC_PROD_END        = 5'd18,
    LC_RMA             = 5'd19,
    LC_SCRAP           = 5'd20
  } lc_state_e;

  // --------------------
  // Translator FSM
  // --------------------

  typedef enum logic [2:0] {
    XL_RESET,
    XL_IDLE,
    XL_NON_DEBUG,
    XL_UNPROV_DEBUG,
    XL_MANUF_NON_DEBUG,
    XL_MANUF_DEBUG,
    XL_PROD_NON_DEBUG,
    XL_PROD_DEBUG
  } xlate_state_e;

  // --------------------
  // Core security state
  // --------------------

  // Encoding 2 is unused
  typedef enum logic [1:0] {
    DEVICE_UNPROVISIONED = 2'd0,
    DEVICE_MANUFACTURING = 2'd1,
    DEVICE_PRODUCTION    = 2'd3
  } device_lifecycle_e;

  typedef struct packed {
    device_lifecycle_e device_lifecycle;
    logic              debug_locked;
  } security_state_t;

  // Most restrictive state, production with debug locked
  localparam security_state_t SEC_STATE_DEFAULT = '{
    device_lifecycle: DEVICE_PRODUCTION,
    debug_locked:     1'b1
  };

endpackage

`default_nettype wire

// File: common/lc_view_if.sv
// Registered lifecycle view from the capture stage
// Read by the translator FSM and the enable gate

`timescale 1ns/1ps
`default_nettype none

interface lc_view_if;
  import lcst_pkg::*;

  // Fuse data valid, qualifies every other field
  logic      valid;
  // Static fuse state, RAW while not valid
  lc_state_e static_state;
  // Decoded requests and errors
  logic      scrap_req;
  logic      state_error;
  logic      raw_unlock;
  logic      manuf_enable;
  // Level and mask matches, token folded in for the SoC enables
  logic      prod_unlock;
  logic      dft_req;
  logic      hw_dbg_req;

  // Capture stage drives every field
  modport capture (
    output valid, static_state, scrap_req, state_error, raw_unlock,
    output manuf_enable, prod_unlock, dft_req, hw_dbg_req
  );

  // Later stages only read
  modport consumer (
    input valid, static_state, scrap_req, state_error, raw_unlock,
    input manuf_enable, prod_unlock, dft_req, hw_dbg_req
  );

endinterface

`default_nettype wire

// File: rtl/lcst_xlate/lc_capture.sv
// Input capture stage
// Decodes tokens, mask matches and scrap request, registered under fuse valid

`timescale 1ns/1ps
`default_nettype none

`include "lcst_defines.svh"

module lc_capture (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     otp_valid_i,
  input  lcst_pkg::lc_state_e      otp_state_i,
  input  logic                     prog_req_i,
  input  lcst_pkg::lc_state_e      prog_state_i,
  input  logic                     raw_unlock_success_i,
  input  logic [`LCST_TOKEN_W-1:0] lc_dft_en_i,
  input  logic [`LCST_TOKEN_W-1:0] lc_hw_debug_en_i,
  input  logic                     state_error_i,
  input  logic                     dbg_manuf_enable_i,
  input  logic [`LCST_MASK_W-1:0]  unlock_level_i,
  input  logic [`LCST_MASK_W-1:0]  dft_mask_i,
  input  logic [`LCST_MASK_W-1:0]  dbg_unlock_mask_i,
  input  logic [`LCST_MASK_W-1:0]  cltap_mask_i,
  lc_view_if.capture               view
);
  import lcst_pkg::*;

  logic dft_tok_on;
  logic hw_tok_on;
  logic dft_hit;
  logic cltap_hit;
  logic prod_hit;
  logic scrap_hit;

  // --------------------
  // Decode
  // --------------------

  // Strict match on the token pattern
  assign dft_tok_on = (lc_dft_en_i == `LCST_TOKEN_ON);
  assign hw_tok_on  = (lc_hw_debug_en_i == `LCST_TOKEN_ON);

  // Any level bit allowed by the mask counts as a hit
  assign dft_hit   = |(unlock_level_i & dft_mask_i);
  assign cltap_hit = |(unlock_level_i & cltap_mask_i);
  assign prod_hit  = |(unlock_level_i & dbg_unlock_mask_i);

  // Scrap only counts with a live program request
  assign scrap_hit = prog_req_i && (prog_state_i == LC_SCRAP);

  // --------------------
  // Capture register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      view.valid        <= 1'b0;
      view.static_state <= LC_RAW;
      view.scrap_req    <= 1'b0;
      view.state_error  <= 1'b0;
      view.raw_unlock   <= 1'b0;
      view.manuf_enable <= 1'b0;
      view.prod_unlock  <= 1'b0;
      view.dft_req      <= 1'b0;
      view.hw_dbg_req   <= 1'b0;
    end else if (otp_valid_i) begin
      view.valid        <= 1'b1;
      view.static_state <= otp_state_i;
      view.scrap_req    <= scrap_hit;
      view.state_error  <= state_error_i;
      view.raw_unlock   <= raw_unlock_success_i;
      view.manuf_enable <= dbg_manuf_enable_i;
      view.prod_unlock  <= prod_hit;
      // Token or mask widening
      view.dft_req      <= dft_tok_on | dft_hit;
      view.hw_dbg_req   <= hw_tok_on | cltap_hit;
    end else begin
      // Fuse data not valid, present an all-clear view
      view.valid        <= 1'b0;
      view.static_state <= LC_RAW;
      view.scrap_req    <= 1'b0;
      view.state_error  <= 1'b0;
      view.raw_unlock   <= 1'b0;
      view.manuf_enable <= 1'b0;
      view.prod_unlock  <= 1'b0;
      view.dft_req      <= 1'b0;
      view.hw_dbg_req   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lcst_xlate/sec_state_fsm.sv
// Translator FSM stage
// Walks the lifecycle branches and registers the core security state

`timescale 1ns/1ps
`default_nettype none

module sec_state_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  lc_view_if.consumer               view,
  output lcst_pkg::security_state_t security_state_o
);
  import lcst_pkg::*;

  xlate_state_e    state_q;
  xlate_state_e    state_d;
  security_state_t sec_d;
  logic            abort;
  logic            is_test_locked;
  logic            is_test_unlocked;

  // Scrap request or reported state error forces non-debug
  assign abort = view.scrap_req | view.state_error;

  assign is_test_locked   = view.static_state inside {[LC_TEST_LOCKED0:LC_TEST_LOCKED6]};
  assign is_test_unlocked = view.static_state inside {[LC_TEST_UNLOCKED0:LC_TEST_UNLOCKED7]};

  // --------------------
  // Next state and output
  // --------------------
  always_comb begin
    state_d = state_q;
    sec_d   = SEC_STATE_DEFAULT;
    case (state_q)
      XL_RESET: begin
        state_d = XL_IDLE;
      end
      XL_IDLE: begin
        // Branch on the fuse state, abort wins
        if (abort || view.static_state == LC_SCRAP) begin
          state_d = XL_NON_DEBUG;
        end else if (view.static_state == LC_RAW || is_test_locked) begin
          state_d = XL_NON_DEBUG;
        end else if (is_test_unlocked) begin
          state_d = XL_UNPROV_DEBUG;
        end else if (view.static_state == LC_DEV) begin
          state_d = XL_MANUF_NON_DEBUG;
        end else if (view.static_state inside {LC_PROD, LC_PROD_END}) begin
          state_d = XL_PROD_NON_DEBUG;
        end else if (view.static_state == LC_RMA) begin
          state_d = XL_PROD_DEBUG;
        end
        // Invalid codes hold in IDLE
      end
      XL_NON_DEBUG: begin
        if (abort) begin
          state_d = XL_NON_DEBUG;
        end else if (view.raw_unlock) begin
          // Volatile RAW unlock
          state_d = XL_UNPROV_DEBUG;
        end
      end
      XL_UNPROV_DEBUG: begin
        if (abort) begin
          state_d = XL_NON_DEBUG;
        end else begin
          sec_d = '{device_lifecycle: DEVICE_UNPROVISIONED, debug_locked: 1'b0};
        end
      end
      XL_MANUF_NON_DEBUG: begin
        if (abort) begin
          state_d = XL_NON_DEBUG;
        end else begin
          sec_d = '{device_lifecycle: DEVICE_MANUFACTURING, debug_locked: 1'b1};
          if (view.manuf_enable) begin
            state_d = XL_MANUF_DEBUG;
          end
        end
      end
      XL_MANUF_DEBUG: begin
        if (abort) begin
          state_d = XL_NON_DEBUG;
        end else begin
          sec_d = '{device_lifecycle: DEVICE_MANUFACTURING, debug_locked: 1'b0};
        end
      end
      XL_PROD_NON_DEBUG: begin
        if (abort) begin
          state_d = XL_NON_DEBUG;
        end else if (view.prod_unlock) begin
          // Level and mask match unlocks production debug
          state_d = XL_PROD_DEBUG;
        end
      end
      XL_PROD_DEBUG: begin
        if (abort) begin
          state_d = XL_NON_DEBUG;
        end else begin
          sec_d = '{device_lifecycle: DEVICE_PRODUCTION, debug_locked: 1'b0};
        end
      end
      default: begin
        state_d = XL_RESET;
      end
    endcase
  end

  // --------------------
  // State and output register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= XL_RESET;
      security_state_o <= SEC_STATE_DEFAULT;
    end else if (view.valid) begin
      state_q          <= state_d;
      security_state_o <= sec_d;
    end else begin
      // Lost fuse data restarts the walk
      state_q          <= XL_RESET;
      security_state_o <= SEC_STATE_DEFAULT;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lcst_xlate/debug_enable_gate.sv
// Debug-enable gate stage
// Registers the SoC DFT and hardware debug enables and the static state

`timescale 1ns/1ps
`default_nettype none

module debug_enable_gate (
  input  logic                clk_i,
  input  logic                rst_ni,
  lc_view_if.consumer         view,
  output logic                soc_dft_en_o,
  output logic                soc_hw_debug_en_o,
  output lcst_pkg::lc_state_e otp_static_state_o
);
  import lcst_pkg::*;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o       <= 1'b0;
      soc_hw_debug_en_o  <= 1'b0;
      otp_static_state_o <= LC_RAW;
    end else begin
      if (view.valid) begin
        // A scrap request kills both enables
        soc_dft_en_o      <= view.dft_req & ~view.scrap_req;
        soc_hw_debug_en_o <= view.hw_dbg_req & ~view.scrap_req;
      end else begin
        soc_dft_en_o      <= 1'b0;
        soc_hw_debug_en_o <= 1'b0;
      end
      // Capture already forces RAW while not valid
      otp_static_state_o <= view.static_state;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lcst_xlate_top.sv
// Lifecycle to security state translator top level
// Capture, translator FSM and debug-enable gate in a three-stage pipe

`timescale 1ns/1ps
`default_nettype none

`include "lcst_defines.svh"

module lcst_xlate_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Fuse controller
  input  logic                              otp_valid_i,
  input  lcst_pkg::lc_state_e               otp_state_i,
  // Lifecycle controller program request and tokens
  input  logic                              prog_req_i,
  input  lcst_pkg::lc_state_e               prog_state_i,
  input  logic                              raw_unlock_success_i,
  input  logic [`LCST_TOKEN_W-1:0]          lc_dft_en_i,
  input  logic [`LCST_TOKEN_W-1:0]          lc_hw_debug_en_i,
  // Error and core-side unlock
  input  logic                              state_error_i,
  input  logic                              dbg_manuf_enable_i,
  input  logic [`LCST_MASK_W-1:0]           unlock_level_i,
  // SoC masks
  input  logic [`LCST_MASK_W-1:0]           dft_mask_i,
  input  logic [`LCST_MASK_W-1:0]           dbg_unlock_mask_i,
  input  logic [`LCST_MASK_W-1:0]           cltap_mask_i,
  // Translated outputs
  output logic                              soc_dft_en_o,
  output logic                              soc_hw_debug_en_o,
  output lcst_pkg::lc_state_e               otp_static_state_o,
  output lcst_pkg::device_lifecycle_e       lifecycle_o,
  output logic                              debug_locked_o
);
  import lcst_pkg::*;

  security_state_t sec_state;

  lc_view_if view ();

  // --------------------
  // Stage 1
  // --------------------
  lc_capture u_capture (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .otp_valid_i          (otp_valid_i),
    .otp_state_i          (otp_state_i),
    .prog_req_i           (prog_req_i),
    .prog_state_i         (prog_state_i),
    .raw_unlock_success_i (raw_unlock_success_i),
    .lc_dft_en_i          (lc_dft_en_i),
    .lc_hw_debug_en_i     (lc_hw_debug_en_i),
    .state_error_i        (state_error_i),
    .dbg_manuf_enable_i   (dbg_manuf_enable_i),
    .unlock_level_i       (unlock_level_i),
    .dft_mask_i           (dft_mask_i),
    .dbg_unlock_mask_i    (dbg_unlock_mask_i),
    .cltap_mask_i         (cltap_mask_i),
    .view                 (view.capture)
  );

  // --------------------
  // Stages 2 and 3
  // --------------------
  sec_state_fsm u_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .view             (view.consumer),
    .security_state_o (sec_state)
  );

  debug_enable_gate u_gate (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .view               (view.consumer),
    .soc_dft_en_o       (soc_dft_en_o),
    .soc_hw_debug_en_o  (soc_hw_debug_en_o),
    .otp_static_state_o (otp_static_state_o)
  );

  // Split the struct onto plain ports
  assign lifecycle_o    = sec_state.device_lifecycle;
  assign debug_locked_o = sec_state.debug_locked;

endmodule

`default_nettype wire

// File: sim/lcst_xlate_props.sv
// Concurrent properties for the translator top level
// Scrap kill, manufacturing unlock origin and valid-loss defaults

`timescale 1ns/1ps
`default_nettype none

module lcst_xlate_props (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        otp_valid_i,
  input logic                        prog_req_i,
  input lcst_pkg::lc_state_e         prog_state_i,
  input logic                        dbg_manuf_enable_i,
  input logic                        dft_en_i,
  input logic                        hw_debug_en_i,
  input lcst_pkg::lc_state_e         static_state_i,
  input lcst_pkg::device_lifecycle_e lifecycle_i,
  input logic                        debug_locked_i
);
  import lcst_pkg::*;

  // Set once a manufacturing enable has been captured
  logic manuf_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      manuf_seen_q <= 1'b0;
    end else if (otp_valid_i && dbg_manuf_enable_i) begin
      manuf_seen_q <= 1'b1;
    end
  end

  // --------------------
  // Properties
  // --------------------

  // Scrap request kills both SoC enables two edges on
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (prog_req_i && prog_state_i == LC_SCRAP) |-> ##2 (!dft_en_i && !hw_debug_en_i))
    else $error("Scrap request left a SoC enable high");

  // Manufacturing debug needs a captured manufacturing enable
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lifecycle_i == DEVICE_MANUFACTURING && !debug_locked_i) |-> manuf_seen_q)
    else $error("Manufacturing debug unlocked without a manufacturing enable");

  // Valid loss puts every output back to its reset value
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !otp_valid_i |-> ##2 (!dft_en_i && !hw_debug_en_i && static_state_i == LC_RAW &&
                          lifecycle_i == DEVICE_PRODUCTION && debug_locked_i))
    else $error("Outputs not at defaults after fuse valid dropped");

endmodule

`default_nettype wire

// File: sim/lcst_xlate_tb.sv
// Testbench for the lifecycle to security state translator
// LCG stimulus checked every cycle against a cycle model of the three stages

`timescale 1ns/1ps
`default_nettype none

`include "lcst_defines.svh"

module lcst_xlate_tb;
  import lcst_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_CYCLES   = 3000;
  // Run length plus reset with a third of margin
  localparam int TIMEOUT_CYCLES = 4000;

  localparam security_state_t SEC_DEFAULT = '{
    device_lifecycle: DEVICE_PRODUCTION,
    debug_locked:     1'b1
  };

  // --------------------
  // DUT signals
  // --------------------
  logic                     clk_i;
  logic                     rst_ni;
  logic                     otp_valid_i;
  lc_state_e                otp_state_i;
  logic                     prog_req_i;
  lc_state_e                prog_state_i;
  logic                     raw_unlock_success_i;
  logic [`LCST_TOKEN_W-1:0] lc_dft_en_i;
  logic [`LCST_TOKEN_W-1:0] lc_hw_debug_en_i;
  logic                     state_error_i;
  logic                     dbg_manuf_enable_i;
  logic [`LCST_MASK_W-1:0]  unlock_level_i;
  logic [`LCST_MASK_W-1:0]  dft_mask_i;
  logic [`LCST_MASK_W-1:0]  dbg_unlock_mask_i;
  logic [`LCST_MASK_W-1:0]  cltap_mask_i;
  logic                     soc_dft_en_o;
  logic                     soc_hw_debug_en_o;
  lc_state_e                otp_static_state_o;
  device_lifecycle_e        lifecycle_o;
  logic                     debug_locked_o;

  // Model of the capture stage view
  logic            m_valid;
  logic            m_scrap;
  logic            m_error;
  logic            m_raw;
  logic            m_manuf;
  logic            m_prod;
  logic            m_dft_req;
  logic            m_hw_req;
  lc_state_e       m_static;
  // Model of the FSM and gate stages
  xlate_state_e    m_state;
  security_state_t m_sec;
  logic            m_dft_en;
  logic            m_hw_en;
  lc_state_e       m_static_out;

  logic [31:0] lcg_state = 32'ha90b;
  logic [4:0]  cur_code;
  int          hold_left;
  int          cycle_count = 0;

  lcst_xlate_top dut_i (.*);

  bind lcst_xlate_top lcst_xlate_props u_props (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .otp_valid_i        (otp_valid_i),
    .prog_req_i         (prog_req_i),
    .prog_state_i       (prog_state_i),
    .dbg_manuf_enable_i (dbg_manuf_enable_i),
    .dft_en_i           (soc_dft_en_o),
    .hw_debug_en_i      (soc_hw_debug_en_o),
    .static_state_i     (otp_static_state_o),
    .lifecycle_i        (lifecycle_o),
    .debug_locked_i     (debug_locked_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // --------------------
  // Random helpers
  // --------------------
  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic lc_state_e code_of(input logic [15:0] v);
    logic [4:0] c;
    c = v[4:0];
    return lc_state_e'(c);
  endfunction

  // One wide bit and one bit from a small low pool so matches do happen
  function automatic logic [63:0] sparse_word();
    logic [15:0] r;
    logic [63:0] w;
    r = rand16();
    w = '0;
    if (r[0]) begin
      w[r[6:1]] = 1'b1;
    end
    if (r[7]) begin
      w[r[9:8]] = 1'b1;
    end
    return w;
  endfunction

  function automatic logic [3:0] token_value();
    logic [15:0] r;
    r = rand16();
    return (r[1:0] == 2'd0) ? `LCST_TOKEN_ON : r[7:4];
  endfunction

  // --------------------
  // Cycle model
  // --------------------

  // IDLE branch from the fuse state
  function automatic xlate_state_e branch_for(input logic [4:0] code, input logic abort);
    if (abort || code == 5'd20) begin
      return XL_NON_DEBUG;
    end else if (code == 5'd0 || (code >= 5'd9 && code <= 5'd15)) begin
      return XL_NON_DEBUG;
    end else if (code >= 5'd1 && code <= 5'd8) begin
      return XL_UNPROV_DEBUG;
    end else if (code == 5'd16) begin
      return XL_MANUF_NON_DEBUG;
    end else if (code == 5'd17 || code == 5'd18) begin
      return XL_PROD_NON_DEBUG;
    end else if (code == 5'd19) begin
      return XL_PROD_DEBUG;
    end
    // Codes 21 and up wait in IDLE
    return XL_IDLE;
  endfunction

  function automatic xlate_state_e xlate_next(input xlate_state_e cur, input logic abort);
    xlate_state_e nxt;
    nxt = cur;
    case (cur)
      XL_RESET: nxt = XL_IDLE;
      XL_IDLE:  nxt = branch_for(m_static, abort);
      XL_NON_DEBUG: begin
        if (!abort && m_raw) begin
          nxt = XL_UNPROV_DEBUG;
        end
      end
      XL_MANUF_NON_DEBUG: begin
        if (abort) begin
          nxt = XL_NON_DEBUG;
        end else if (m_manuf) begin
          nxt = XL_MANUF_DEBUG;
        end
      end
      XL_PROD_NON_DEBUG: begin
        if (abort) begin
          nxt = XL_NON_DEBUG;
        end else if (m_prod) begin
          nxt = XL_PROD_DEBUG;
        end
      end
      default: begin
        if (abort) begin
          nxt = XL_NON_DEBUG;
        end
      end
    endcase
    return nxt;
  endfunction

  function automatic security_state_t make_sec(input device_lifecycle_e lc, input logic locked);
    security_state_t s;
    s.device_lifecycle = lc;
    s.debug_locked     = locked;
    return s;
  endfunction

  // Value the current state presents or the default on abort
  function automatic security_state_t sec_of(input xlate_state_e cur, input logic abort);
    if (abort) begin
      return SEC_DEFAULT;
    end
    case (cur)
      XL_UNPROV_DEBUG:    return make_sec(DEVICE_UNPROVISIONED, 1'b0);
      XL_MANUF_NON_DEBUG: return make_sec(DEVICE_MANUFACTURING, 1'b1);
      XL_MANUF_DEBUG:     return make_sec(DEVICE_MANUFACTURING, 1'b0);
      XL_PROD_DEBUG:      return make_sec(DEVICE_PRODUCTION, 1'b0);
      default:            return SEC_DEFAULT;
    endcase
  endfunction

  task automatic clear_view();
    m_valid   = 1'b0;
    m_static  = LC_RAW;
    m_scrap   = 1'b0;
    m_error   = 1'b0;
    m_raw     = 1'b0;
    m_manuf   = 1'b0;
    m_prod    = 1'b0;
    m_dft_req = 1'b0;
    m_hw_req  = 1'b0;
  endtask

  task automatic model_reset();
    clear_view();
    m_state      = XL_RESET;
    m_sec        = SEC_DEFAULT;
    m_dft_en     = 1'b0;
    m_hw_en      = 1'b0;
    m_static_out = LC_RAW;
  endtask

  // One clock edge with later stages first so they see the old view
  task automatic model_step();
    logic abort;
    if (!rst_ni) begin
      model_reset();
    end else begin
      abort        = m_scrap | m_error;
      m_dft_en     = m_valid & m_dft_req & ~m_scrap;
      m_hw_en      = m_valid & m_hw_req & ~m_scrap;
      m_static_out = m_static;
      m_sec        = m_valid ? sec_of(m_state, abort) : SEC_DEFAULT;
      m_state      = m_valid ? xlate_next(m_state, abort) : XL_RESET;
      if (otp_valid_i) begin
        m_valid   = 1'b1;
        m_static  = otp_state_i;
        m_scrap   = prog_req_i && (prog_state_i == LC_SCRAP);
        m_error   = state_error_i;
        m_raw     = raw_unlock_success_i;
        m_manuf   = dbg_manuf_enable_i;
        m_prod    = (unlock_level_i & dbg_unlock_mask_i) != '0;
        m_dft_req = (lc_dft_en_i == `LCST_TOKEN_ON) || ((unlock_level_i & dft_mask_i) != '0);
        m_hw_req  = (lc_hw_debug_en_i == `LCST_TOKEN_ON) ||
                    ((unlock_level_i & cltap_mask_i) != '0);
      end else begin
        clear_view();
      end
    end
  endtask

  // --------------------
  // Checks
  // --------------------
  task stop_run();
    $display("Verification failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL time=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_outputs();
    check_val("soc_dft_en_o", soc_dft_en_o, m_dft_en);
    check_val("soc_hw_debug_en_o", soc_hw_debug_en_o, m_hw_en);
    check_val("otp_static_state_o", otp_static_state_o, m_static_out);
    check_val("lifecycle_o", lifecycle_o, m_sec.device_lifecycle);
    check_val("debug_locked_o", debug_locked_o, m_sec.debug_locked);
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_stimulus();
    logic [15:0] r;
    if (hold_left == 0) begin
      r         = rand16();
      // 21 to 23 are invalid codes
      cur_code  = 5'(r % 24);
      hold_left = 4 + int'(r[10:8]);
    end
    hold_left--;
    otp_state_i          = lc_state_e'(cur_code);
    otp_valid_i          = (rand16() % 16) != 0;
    r                    = rand16();
    if (r % 20 == 0) begin
      prog_req_i   = 1'b1;
      prog_state_i = LC_SCRAP;
    end else begin
      // SCRAP only shows up with the request low here
      prog_req_i   = r[0];
      prog_state_i = code_of(r[0] ? r[15:1] % 20 : r[15:1] % 21);
    end
    state_error_i        = (rand16() % 32) == 0;
    raw_unlock_success_i = (rand16() % 8) == 0;
    dbg_manuf_enable_i   = (rand16() % 8) == 0;
    lc_dft_en_i          = token_value();
    lc_hw_debug_en_i     = token_value();
    unlock_level_i       = sparse_word() | sparse_word();
    dft_mask_i           = sparse_word();
    dbg_unlock_mask_i    = sparse_word();
    cltap_mask_i         = sparse_word();
  endtask

  // Hard limit on the run
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  initial begin
    clk_i                = 1'b0;
    rst_ni               = 1'b0;
    otp_valid_i          = 1'b0;
    otp_state_i          = LC_RAW;
    prog_req_i           = 1'b0;
    prog_state_i         = LC_RAW;
    raw_unlock_success_i = 1'b0;
    lc_dft_en_i          = '0;
    lc_hw_debug_en_i     = '0;
    state_error_i        = 1'b0;
    dbg_manuf_enable_i   = 1'b0;
    unlock_level_i       = '0;
    dft_mask_i           = '0;
    dbg_unlock_mask_i    = '0;
    cltap_mask_i         = '0;
    cur_code             = '0;
    hold_left            = 0;
    model_reset();

    // Outputs sit at their defaults during reset
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
      model_step();
      #1;
      check_outputs();
    end
    rst_ni = 1'b1;
    drive_stimulus();

    // Random run that compares then drives after each edge
    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(posedge clk_i);
      model_step();
      #1;
      check_outputs();
      drive_stimulus();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: lcst_xlate.f
+incdir+common
common/lcst_pkg.sv
common/lc_view_if.sv
rtl/lcst_xlate/lc_capture.sv
rtl/lcst_xlate/sec_state_fsm.sv
rtl/lcst_xlate/debug_enable_gate.sv
rtl/lcst_xlate_top.sv
sim/lcst_xlate_props.sv
sim/lcst_xlate_tb.sv

// File: Bender.yml
package:
  name: lcst_xlate

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lcst_pkg.sv
      - common/lc_view_if.sv
      - rtl/lcst_xlate/lc_capture.sv
      - rtl/lcst_xlate/sec_state_fsm.sv
      - rtl/lcst_xlate/debug_enable_gate.sv
      - rtl/lcst_xlate_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/lcst_xlate_props.sv
      - sim/lcst_xlate_tb.sv
